/* l2_mem_pkg.sv */
// ######################################
// l2 slice store: cache geometry, mixed
// word layout and stable state encoding
// ######################################
`default_nettype none

package l2_mem_pkg;

    // geometry
    localparam int L2_WAYS           = 4;
    localparam int L2_WAY_BITS       = 2;
    localparam int L2_SETS           = 64;
    localparam int L2_SET_BITS       = 6;
    localparam int L2_BANKS          = 2;
    localparam int L2_BANK_DEPTH     = 32;
    localparam int L2_BANK_ADDR_BITS = 5;
    localparam int L2_TAG_BITS       = 12;
    localparam int STATE_BITS        = 3;
    localparam int LINE_BITS         = 128;
    localparam int LINE_HALF_BITS    = 64;
    localparam int MIXED_BITS        = 24;

    // mixed word is {hprot, state, 8'b0, tag}
    localparam int MIXED_HPROT_POS = 23;
    localparam int MIXED_STATE_HI  = 22;
    localparam int MIXED_STATE_LO  = 20;
    localparam int MIXED_TAG_HI    = 11;
    localparam int MIXED_TAG_LO    = 0;

    typedef logic [L2_SET_BITS-1:0] l2_set_t;
    typedef logic [L2_WAY_BITS-1:0] l2_way_t;
    typedef logic [L2_TAG_BITS-1:0] l2_tag_t;
    typedef logic [STATE_BITS-1:0]  state_t;
    typedef logic                   hprot_t;
    typedef logic [LINE_BITS-1:0]   line_t;
    typedef logic [MIXED_BITS-1:0]  mixed_t;

    // any nonzero state is a valid line
    localparam state_t STATE_INVALID   = 3'd0;
    localparam state_t STATE_SHARED    = 3'd1;
    localparam state_t STATE_EXCLUSIVE = 3'd2;
    localparam state_t STATE_MODIFIED  = 3'd3;

endpackage

`default_nettype wire

/* l2_wr_if.sv */
// ######################################
// write port of the l2 local memory
// ######################################
`default_nettype none

interface l2_wr_if;
    import l2_mem_pkg::*;

    // one-cycle strobes
    logic    wr_en_line;
    logic    wr_en_state;
    logic    wr_en_put;
    logic    wr_en_evict;
    logic    wr_rst;

    l2_way_t way;
    line_t   data_line;
    l2_tag_t data_tag;
    hprot_t  data_hprot;
    state_t  data_state;
    l2_way_t data_evict_way;

    modport src (
        output wr_en_line, wr_en_state, wr_en_put, wr_en_evict, wr_rst,
        output way, data_line, data_tag, data_hprot, data_state, data_evict_way
    );

    modport dst (
        input wr_en_line, wr_en_state, wr_en_put, wr_en_evict, wr_rst,
        input way, data_line, data_tag, data_hprot, data_state, data_evict_way
    );

endinterface

`default_nettype wire

/* sram_sp.sv */
// ######################################
// single-port sram, bit write mask,
// registered read data
// ######################################
`default_nettype none

module sram_sp #(
    parameter int DATA_WIDTH = 64,
    parameter int NUM_WORDS  = l2_mem_pkg::L2_BANK_DEPTH
) (
    input  logic                                     clk,
    input  logic                                     req_i,
    input  logic                                     we_i,
    input  logic [l2_mem_pkg::L2_BANK_ADDR_BITS-1:0] addr_i,
    input  logic [DATA_WIDTH-1:0]                    wdata_i,
    input  logic [DATA_WIDTH-1:0]                    be_i,
    output logic [DATA_WIDTH-1:0]                    rdata_o
);

    logic [DATA_WIDTH-1:0] mem [NUM_WORDS];

    always_ff @(posedge clk) begin
        if (req_i) begin
            if (we_i) begin
                // only bits set in be_i change
                mem[addr_i] <= (mem[addr_i] & ~be_i) | (wdata_i & be_i);
            end else begin
                rdata_o <= mem[addr_i];
            end
        end
    end

endmodule

`default_nettype wire

/* l2_localmem.sv */
// ######################################
// l2 local memory: banked per-way line
// and mixed srams, eviction-way table
// ######################################
`default_nettype none

module l2_localmem (
    input  logic                clk,
    input  logic                rst,
    input  logic                rd_en_i,
    input  l2_mem_pkg::l2_set_t set_i,
    l2_wr_if.dst                wr,
    output l2_mem_pkg::line_t   rd_line_o  [l2_mem_pkg::L2_WAYS],
    output l2_mem_pkg::l2_tag_t rd_tag_o   [l2_mem_pkg::L2_WAYS],
    output l2_mem_pkg::state_t  rd_state_o [l2_mem_pkg::L2_WAYS],
    output l2_mem_pkg::hprot_t  rd_hprot_o [l2_mem_pkg::L2_WAYS],
    output l2_mem_pkg::l2_way_t evict_way_o
);
    import l2_mem_pkg::*;

    logic [L2_WAYS-1:0]  way_en;
    logic [L2_BANKS-1:0] bank_en;
    logic                mixed_wr;
    logic                line_wr;
    logic                bank_sel_q;
    mixed_t              wr_mixed;
    mixed_t              wr_mixed_mask;

    mixed_t                    rd_mixed [L2_WAYS][L2_BANKS];
    logic [LINE_HALF_BITS-1:0] rd_half  [L2_WAYS][L2_BANKS][2];

    l2_way_t evict_tbl [L2_SETS];

    // a set reset hits every way of the set
    always_comb begin
        for (int i = 0; i < L2_WAYS; i++) begin
            way_en[i] = wr.wr_rst || (wr.way == l2_way_t'(i));
        end
    end

    // top set bit picks the bank
    always_comb begin
        for (int j = 0; j < L2_BANKS; j++) begin
            bank_en[j] = (set_i[L2_SET_BITS-1] == 1'(j));
        end
    end

    assign mixed_wr = wr.wr_en_put | wr.wr_en_state | wr.wr_rst;
    assign line_wr  = wr.wr_en_put | wr.wr_en_line;

    always_comb begin
        wr_mixed = '0;
        wr_mixed[MIXED_HPROT_POS] = wr.data_hprot;
        wr_mixed[MIXED_STATE_HI:MIXED_STATE_LO] = wr.wr_rst ? STATE_INVALID : wr.data_state;
        wr_mixed[MIXED_TAG_HI:MIXED_TAG_LO] = wr.data_tag;

        wr_mixed_mask = '0;
        if (wr.wr_en_put) begin
            wr_mixed_mask[MIXED_HPROT_POS] = 1'b1;
            wr_mixed_mask[MIXED_TAG_HI:MIXED_TAG_LO] = '1;
        end
        if (mixed_wr) begin
            wr_mixed_mask[MIXED_STATE_HI:MIXED_STATE_LO] = '1;
        end
    end

    for (genvar i = 0; i < L2_WAYS; i++) begin : g_way
        for (genvar j = 0; j < L2_BANKS; j++) begin : g_bank
            logic mixed_we;
            logic line_we;

            assign mixed_we = way_en[i] & bank_en[j] & mixed_wr;
            assign line_we  = way_en[i] & bank_en[j] & line_wr;

            sram_sp #(
                .DATA_WIDTH (MIXED_BITS),
                .NUM_WORDS  (L2_BANK_DEPTH)
            ) u_mixed (
                .clk     (clk),
                .req_i   (rd_en_i | mixed_we),
                .we_i    (mixed_we),
                .addr_i  (set_i[L2_BANK_ADDR_BITS-1:0]),
                .wdata_i (wr_mixed),
                .be_i    (wr_mixed_mask),
                .rdata_o (rd_mixed[i][j])
            );

            // 128-bit line kept as two 64-bit halves
            for (genvar k = 0; k < 2; k++) begin : g_half
                sram_sp #(
                    .DATA_WIDTH (LINE_HALF_BITS),
                    .NUM_WORDS  (L2_BANK_DEPTH)
                ) u_line (
                    .clk     (clk),
                    .req_i   (rd_en_i | line_we),
                    .we_i    (line_we),
                    .addr_i  (set_i[L2_BANK_ADDR_BITS-1:0]),
                    .wdata_i (wr.data_line[LINE_HALF_BITS*k +: LINE_HALF_BITS]),
                    .be_i    ({LINE_HALF_BITS{1'b1}}),
                    .rdata_o (rd_half[i][j][k])
                );
            end
        end
    end

    // bank of the last read, held with the sram outputs
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            bank_sel_q <= 1'b0;
        end else if (rd_en_i) begin
            bank_sel_q <= set_i[L2_SET_BITS-1];
        end
    end

    always_comb begin
        for (int i = 0; i < L2_WAYS; i++) begin
            rd_hprot_o[i] = rd_mixed[i][bank_sel_q][MIXED_HPROT_POS];
            rd_state_o[i] = rd_mixed[i][bank_sel_q][MIXED_STATE_HI:MIXED_STATE_LO];
            rd_tag_o[i]   = rd_mixed[i][bank_sel_q][MIXED_TAG_HI:MIXED_TAG_LO];
            rd_line_o[i]  = {rd_half[i][bank_sel_q][1], rd_half[i][bank_sel_q][0]};
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int s = 0; s < L2_SETS; s++) begin
                evict_tbl[s] <= '0;
            end
            evict_way_o <= '0;
        end else begin
            if (wr.wr_en_evict) begin
                evict_tbl[set_i] <= wr.data_evict_way;
            end
            evict_way_o <= evict_tbl[set_i];
        end
    end

endmodule

`default_nettype wire

/* l2_tag_lookup.sv */
// ######################################
// tag compare over all ways, selects the
// lowest hitting way and its data
// ######################################
`default_nettype none

module l2_tag_lookup (
    input  logic                clk,
    input  logic                rst,
    input  logic                rd_en_i,
    input  l2_mem_pkg::l2_tag_t tag_i,
    input  l2_mem_pkg::l2_tag_t rd_tag_i   [l2_mem_pkg::L2_WAYS],
    input  l2_mem_pkg::state_t  rd_state_i [l2_mem_pkg::L2_WAYS],
    input  l2_mem_pkg::hprot_t  rd_hprot_i [l2_mem_pkg::L2_WAYS],
    input  l2_mem_pkg::line_t   rd_line_i  [l2_mem_pkg::L2_WAYS],
    output logic                valid_o,
    output logic                hit_o,
    output l2_mem_pkg::l2_way_t hit_way_o,
    output l2_mem_pkg::line_t   line_o,
    output l2_mem_pkg::state_t  state_o,
    output l2_mem_pkg::hprot_t  hprot_o
);
    import l2_mem_pkg::*;

    logic               valid_q;
    l2_tag_t            tag_q;
    logic [L2_WAYS-1:0] way_hit;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= rd_en_i;
        end
    end

    // tag lines up with the sram read of the same edge
    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            tag_q <= tag_i;
        end
    end

    always_comb begin
        for (int i = 0; i < L2_WAYS; i++) begin
            way_hit[i] = valid_q && (rd_state_i[i] != STATE_INVALID) && (rd_tag_i[i] == tag_q);
        end
    end

    // walk down so the lowest way is the one left standing
    always_comb begin
        hit_o     = 1'b0;
        hit_way_o = '0;
        line_o    = '0;
        state_o   = STATE_INVALID;
        hprot_o   = 1'b0;
        for (int i = L2_WAYS - 1; i >= 0; i--) begin
            if (way_hit[i]) begin
                hit_o     = 1'b1;
                hit_way_o = l2_way_t'(i);
                line_o    = rd_line_i[i];
                state_o   = rd_state_i[i];
                hprot_o   = rd_hprot_i[i];
            end
        end
    end

    assign valid_o = valid_q;

endmodule

`default_nettype wire

/* l2_mem_top.sv */
// ######################################
// l2 slice store top: local memory and
// tag lookup behind plain ports
// ######################################
`default_nettype none

module l2_mem_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                rd_en_i,
    input  l2_mem_pkg::l2_set_t set_i,
    input  l2_mem_pkg::l2_tag_t lookup_tag_i,
    input  logic                wr_line_i,
    input  logic                wr_state_i,
    input  logic                wr_put_i,
    input  logic                wr_evict_i,
    input  logic                wr_rst_i,
    input  l2_mem_pkg::l2_way_t wr_way_i,
    input  l2_mem_pkg::line_t   wr_line_data_i,
    input  l2_mem_pkg::l2_tag_t wr_tag_i,
    input  l2_mem_pkg::hprot_t  wr_hprot_i,
    input  l2_mem_pkg::state_t  wr_state_data_i,
    input  l2_mem_pkg::l2_way_t wr_evict_way_i,
    output logic                lookup_valid_o,
    output logic                hit_o,
    output l2_mem_pkg::l2_way_t hit_way_o,
    output l2_mem_pkg::line_t   hit_line_o,
    output l2_mem_pkg::state_t  hit_state_o,
    output l2_mem_pkg::hprot_t  hit_hprot_o,
    output l2_mem_pkg::l2_way_t evict_way_o
);
    import l2_mem_pkg::*;

    l2_wr_if wr_bus ();

    line_t   rd_line  [L2_WAYS];
    l2_tag_t rd_tag   [L2_WAYS];
    state_t  rd_state [L2_WAYS];
    hprot_t  rd_hprot [L2_WAYS];

    assign wr_bus.wr_en_line     = wr_line_i;
    assign wr_bus.wr_en_state    = wr_state_i;
    assign wr_bus.wr_en_put      = wr_put_i;
    assign wr_bus.wr_en_evict    = wr_evict_i;
    assign wr_bus.wr_rst         = wr_rst_i;
    assign wr_bus.way            = wr_way_i;
    assign wr_bus.data_line      = wr_line_data_i;
    assign wr_bus.data_tag       = wr_tag_i;
    assign wr_bus.data_hprot     = wr_hprot_i;
    assign wr_bus.data_state     = wr_state_data_i;
    assign wr_bus.data_evict_way = wr_evict_way_i;

    l2_localmem u_mem (
        .clk         (clk),
        .rst         (rst),
        .rd_en_i     (rd_en_i),
        .set_i       (set_i),
        .wr          (wr_bus.dst),
        .rd_line_o   (rd_line),
        .rd_tag_o    (rd_tag),
        .rd_state_o  (rd_state),
        .rd_hprot_o  (rd_hprot),
        .evict_way_o (evict_way_o)
    );

    l2_tag_lookup u_lookup (
        .clk        (clk),
        .rst        (rst),
        .rd_en_i    (rd_en_i),
        .tag_i      (lookup_tag_i),
        .rd_tag_i   (rd_tag),
        .rd_state_i (rd_state),
        .rd_hprot_i (rd_hprot),
        .rd_line_i  (rd_line),
        .valid_o    (lookup_valid_o),
        .hit_o      (hit_o),
        .hit_way_o  (hit_way_o),
        .line_o     (hit_line_o),
        .state_o    (hit_state_o),
        .hprot_o    (hit_hprot_o)
    );

endmodule

`default_nettype wire

/* l2_mem_chk.sv */
// ######################################
// l2 slice store protocol checks
// ######################################
`default_nettype none

module l2_mem_chk (
    input logic clk,
    input logic rst,
    input logic rd_en_i,
    input logic wr_line_i,
    input logic wr_state_i,
    input logic wr_put_i,
    input logic wr_evict_i,
    input logic wr_rst_i,
    input logic lookup_valid_i,
    input logic hit_i
);

    logic any_wr;
    logic assert_failed = 1'b0;

    assign any_wr = wr_line_i | wr_state_i | wr_put_i | wr_evict_i | wr_rst_i;

    // srams are single-port
    a_rd_wr_excl: assert property (@(posedge clk) disable iff (!rst) !(rd_en_i && any_wr))
        else begin
            $error("read strobe and write strobe high in the same cycle");
            assert_failed = 1'b1;
        end

    a_valid_in_reset: assert property (@(posedge clk) !rst |-> !lookup_valid_i)
        else begin
            $error("lookup valid high during reset");
            assert_failed = 1'b1;
        end

    a_hit_valid: assert property (@(posedge clk) disable iff (!rst) hit_i |-> lookup_valid_i)
        else begin
            $error("hit without lookup valid");
            assert_failed = 1'b1;
        end

endmodule

`default_nettype wire

/* l2_mem_top_tb.sv */
// ######################################
// testbench for the l2 slice store
// ######################################
`default_nettype none

module l2_mem_top_tb;
    import l2_mem_pkg::*;

    localparam int CLK_PERIOD      = 100;
    localparam int RESET_CYCLES    = 3;
    localparam int LOOKUP_TIMEOUT  = 8;
    localparam int NUM_MISS_PROBES = 16;

    typedef enum int {
        OP_RST_SET, OP_PUT, OP_STATE, OP_LINE, OP_EVICT, OP_LOOKUP
    } op_e;

    typedef struct {
        op_e     op;
        l2_set_t set_idx;
        l2_way_t way;
        l2_tag_t tag;
        state_t  state;
        logic    exp_hit;
        l2_way_t exp_way;
    } step_t;

    logic    clk;
    logic    rst;
    logic    rd_en_i;
    l2_set_t set_i;
    l2_tag_t lookup_tag_i;
    logic    wr_line_i;
    logic    wr_state_i;
    logic    wr_put_i;
    logic    wr_evict_i;
    logic    wr_rst_i;
    l2_way_t wr_way_i;
    line_t   wr_line_data_i;
    l2_tag_t wr_tag_i;
    hprot_t  wr_hprot_i;
    state_t  wr_state_data_i;
    l2_way_t wr_evict_way_i;
    logic    lookup_valid_o;
    logic    hit_o;
    l2_way_t hit_way_o;
    line_t   hit_line_o;
    state_t  hit_state_o;
    hprot_t  hit_hprot_o;
    l2_way_t evict_way_o;

    // reference model of the store
    l2_tag_t m_tag   [L2_SETS][L2_WAYS];
    state_t  m_state [L2_SETS][L2_WAYS];
    hprot_t  m_hprot [L2_SETS][L2_WAYS];
    line_t   m_line  [L2_SETS][L2_WAYS];
    l2_way_t m_evict [L2_SETS];

    step_t       steps [$];
    logic [15:0] lfsr_state;

    l2_mem_top u_dut (.*);

    bind l2_mem_top l2_mem_chk u_chk (
        .clk            (clk),
        .rst            (rst),
        .rd_en_i        (rd_en_i),
        .wr_line_i      (wr_line_i),
        .wr_state_i     (wr_state_i),
        .wr_put_i       (wr_put_i),
        .wr_evict_i     (wr_evict_i),
        .wr_rst_i       (wr_rst_i),
        .lookup_valid_i (lookup_valid_o),
        .hit_i          (hit_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // fibonacci lfsr, taps 16/14/13/11, one step per bit
    function automatic logic [127:0] lfsr_bits(input int n);
        logic [127:0] r;
        logic         fb;
        r = '0;
        for (int b = 0; b < n; b++) begin
            fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], fb};
            r = {r[126:0], fb};
        end
        return r;
    endfunction

    function automatic void add_step(input op_e op, input int s, input int w, input int t,
                                     input state_t st, input logic eh, input int ew);
        step_t e;
        e.op      = op;
        e.set_idx = l2_set_t'(s);
        e.way     = l2_way_t'(w);
        e.tag     = l2_tag_t'(t);
        e.state   = st;
        e.exp_hit = eh;
        e.exp_way = l2_way_t'(ew);
        steps.push_back(e);
    endfunction

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic value_mismatch(input string msg);
        abort_run($sformatf("[FAIL] t=%0t %s", $time, msg));
    endtask

    task automatic check_hit(input logic got_hit, input l2_way_t got_way,
                             input logic exp_hit, input l2_way_t exp_way, input string what);
        if (got_hit !== exp_hit || got_way !== exp_way) begin
            value_mismatch($sformatf("%s hit/way got %b/%0d exp %b/%0d",
                                     what, got_hit, got_way, exp_hit, exp_way));
        end
    endtask

    task automatic check_line(input line_t got, input line_t exp, input string what);
        if (got !== exp) begin
            value_mismatch($sformatf("%s line got %h exp %h", what, got, exp));
        end
    endtask

    task automatic check_state(input state_t got, input state_t exp, input string what);
        if (got !== exp) begin
            value_mismatch($sformatf("%s state got %0d exp %0d", what, got, exp));
        end
    endtask

    task automatic check_hprot(input hprot_t got, input hprot_t exp, input string what);
        if (got !== exp) begin
            value_mismatch($sformatf("%s hprot got %b exp %b", what, got, exp));
        end
    endtask

    task automatic check_way(input l2_way_t got, input l2_way_t exp, input string what);
        if (got !== exp) begin
            value_mismatch($sformatf("%s way got %0d exp %0d", what, got, exp));
        end
    endtask

    task automatic write_pulse(input op_e op, input l2_set_t s, input l2_way_t w,
                               input l2_tag_t t, input state_t st, input line_t ln,
                               input hprot_t hp);
        @(posedge clk);
        set_i           <= s;
        wr_way_i        <= w;
        wr_evict_way_i  <= w;
        wr_tag_i        <= t;
        wr_state_data_i <= st;
        wr_line_data_i  <= ln;
        wr_hprot_i      <= hp;
        case (op)
            OP_RST_SET: wr_rst_i   <= 1'b1;
            OP_PUT:     wr_put_i   <= 1'b1;
            OP_STATE:   wr_state_i <= 1'b1;
            OP_LINE:    wr_line_i  <= 1'b1;
            OP_EVICT:   wr_evict_i <= 1'b1;
            default:    ;
        endcase
        @(posedge clk);
        wr_rst_i   <= 1'b0;
        wr_put_i   <= 1'b0;
        wr_state_i <= 1'b0;
        wr_line_i  <= 1'b0;
        wr_evict_i <= 1'b0;
    endtask

    task automatic wait_lookup_valid();
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!lookup_valid_o && cycles < LOOKUP_TIMEOUT);
        if (!lookup_valid_o) begin
            abort_run($sformatf("lookup valid never came within %0d cycles, t=%0t",
                                LOOKUP_TIMEOUT, $time));
        end
    endtask

    task automatic do_lookup(input l2_set_t s, input l2_tag_t t,
                             input logic exp_hit, input l2_way_t exp_way);
        string what;
        what = $sformatf("lookup set %0d tag %h", s, t);
        @(posedge clk);
        rd_en_i      <= 1'b1;
        set_i        <= s;
        lookup_tag_i <= t;
        @(posedge clk);
        rd_en_i <= 1'b0;
        wait_lookup_valid();
        check_hit(hit_o, hit_way_o, exp_hit, exp_way, what);
        if (exp_hit) begin
            check_line(hit_line_o, m_line[s][exp_way], what);
            check_state(hit_state_o, m_state[s][exp_way], what);
            check_hprot(hit_hprot_o, m_hprot[s][exp_way], what);
        end else begin
            check_line(hit_line_o, '0, what);
            check_state(hit_state_o, STATE_INVALID, what);
            check_hprot(hit_hprot_o, 1'b0, what);
        end
    endtask

    // pointer register follows set_i one cycle later
    task automatic check_evict_all();
        for (int s = 0; s < L2_SETS; s++) begin
            @(posedge clk);
            set_i <= l2_set_t'(s);
            @(posedge clk);
            @(negedge clk);
            check_way(evict_way_o, m_evict[s], $sformatf("evict pointer set %0d", s));
        end
    endtask

    task automatic apply_step(input step_t e);
        line_t  ln;
        hprot_t hp;
        // bus data differs from the stored fields, so a stray write shows up
        ln = ~m_line[e.set_idx][e.way];
        hp = ~m_hprot[e.set_idx][e.way];
        if (e.op == OP_PUT || e.op == OP_LINE) begin
            ln = line_t'(lfsr_bits(LINE_BITS));
        end
        if (e.op == OP_PUT) begin
            hp = hprot_t'(lfsr_bits(1));
        end
        case (e.op)
            OP_LOOKUP: do_lookup(e.set_idx, e.tag, e.exp_hit, e.exp_way);
            default:   write_pulse(e.op, e.set_idx, e.way, e.tag, e.state, ln, hp);
        endcase
        case (e.op)
            OP_RST_SET: begin
                for (int w = 0; w < L2_WAYS; w++) begin
                    m_state[e.set_idx][w] = STATE_INVALID;
                end
            end
            OP_PUT: begin
                m_tag[e.set_idx][e.way]   = e.tag;
                m_state[e.set_idx][e.way] = e.state;
                m_hprot[e.set_idx][e.way] = hp;
                m_line[e.set_idx][e.way]  = ln;
            end
            OP_STATE: m_state[e.set_idx][e.way] = e.state;
            OP_LINE:  m_line[e.set_idx][e.way] = ln;
            OP_EVICT: begin
                m_evict[e.set_idx] = e.way;
                @(posedge clk);
                @(negedge clk);
                check_way(evict_way_o, e.way, $sformatf("evict write set %0d", e.set_idx));
            end
            default: ;
        endcase
    endtask

    initial begin
        lfsr_state      = 16'd37708;
        rst             = 1'b0;
        rd_en_i         = 1'b0;
        set_i           = '0;
        lookup_tag_i    = '0;
        wr_line_i       = 1'b0;
        wr_state_i      = 1'b0;
        wr_put_i        = 1'b0;
        wr_evict_i      = 1'b0;
        wr_rst_i        = 1'b0;
        wr_way_i        = '0;
        wr_line_data_i  = '0;
        wr_tag_i        = '0;
        wr_hprot_i      = 1'b0;
        wr_state_data_i = STATE_INVALID;
        wr_evict_way_i  = '0;
        for (int s = 0; s < L2_SETS; s++) begin
            m_evict[s] = '0;
            for (int w = 0; w < L2_WAYS; w++) begin
                m_tag[s][w]   = '0;
                m_state[s][w] = STATE_INVALID;
                m_hprot[s][w] = 1'b0;
                m_line[s][w]  = '0;
            end
        end

        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b1;

        check_evict_all();
        for (int s = 0; s < L2_SETS; s++) begin
            write_pulse(OP_RST_SET, l2_set_t'(s), '0, '0, STATE_INVALID, '0, 1'b0);
        end
        for (int p = 0; p < NUM_MISS_PROBES; p++) begin
            do_lookup(l2_set_t'(lfsr_bits(L2_SET_BITS)), l2_tag_t'(lfsr_bits(L2_TAG_BITS)),
                      1'b0, '0);
        end

        // sets 5 and 37 share a bank address in different banks
        add_step(OP_PUT,    5,  1, 'h123, STATE_SHARED,    1'b0, 0);
        add_step(OP_LOOKUP, 5,  0, 'h123, STATE_INVALID,   1'b1, 1);
        add_step(OP_PUT,    37, 2, 'h123, STATE_EXCLUSIVE, 1'b0, 0);
        add_step(OP_LOOKUP, 37, 0, 'h123, STATE_INVALID,   1'b1, 2);
        add_step(OP_LOOKUP, 5,  0, 'h123, STATE_INVALID,   1'b1, 1);
        add_step(OP_LOOKUP, 5,  0, 'h124, STATE_INVALID,   1'b0, 0);
        add_step(OP_STATE,  5,  1, 'h000, STATE_MODIFIED,  1'b0, 0);
        add_step(OP_LOOKUP, 5,  0, 'h123, STATE_INVALID,   1'b1, 1);
        add_step(OP_LINE,   37, 2, 'h000, STATE_INVALID,   1'b0, 0);
        add_step(OP_LOOKUP, 37, 0, 'h123, STATE_INVALID,   1'b1, 2);
        add_step(OP_PUT,    20, 3, 'habc, STATE_SHARED,    1'b0, 0);
        add_step(OP_PUT,    20, 0, 'habc, STATE_EXCLUSIVE, 1'b0, 0);
        add_step(OP_LOOKUP, 20, 0, 'habc, STATE_INVALID,   1'b1, 0);
        add_step(OP_LOOKUP, 5,  0, 'h123, STATE_INVALID,   1'b1, 1);
        add_step(OP_STATE,  20, 0, 'h000, STATE_INVALID,   1'b0, 0);
        add_step(OP_LOOKUP, 20, 0, 'habc, STATE_INVALID,   1'b1, 3);
        add_step(OP_STATE,  20, 3, 'h000, STATE_INVALID,   1'b0, 0);
        add_step(OP_LOOKUP, 20, 0, 'habc, STATE_INVALID,   1'b0, 0);
        // a set reset stores state zero whatever the state data
        add_step(OP_RST_SET, 37, 0, 'h000, STATE_MODIFIED, 1'b0, 0);
        add_step(OP_LOOKUP, 37, 0, 'h123, STATE_INVALID,   1'b0, 0);
        add_step(OP_LOOKUP, 5,  0, 'h123, STATE_INVALID,   1'b1, 1);
        add_step(OP_PUT,    63, 0, 'hfff, STATE_MODIFIED,  1'b0, 0);
        add_step(OP_LOOKUP, 63, 0, 'hfff, STATE_INVALID,   1'b1, 0);
        add_step(OP_EVICT,  5,  3, 'h000, STATE_INVALID,   1'b0, 0);
        add_step(OP_EVICT,  37, 2, 'h000, STATE_INVALID,   1'b0, 0);
        add_step(OP_EVICT,  63, 1, 'h000, STATE_INVALID,   1'b0, 0);

        foreach (steps[i]) begin
            apply_step(steps[i]);
        end
        check_evict_all();

        if (u_dut.u_chk.assert_failed) begin
            $display("an assertion in the bound checker failed");
            $display("STATUS: FAIL");
            $fatal(1, "assertion failure");
        end else begin
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* l2_mem_top.f */
l2_mem_pkg.sv
l2_wr_if.sv
sram_sp.sv
l2_localmem.sv
l2_tag_lookup.sv
l2_mem_top.sv
l2_mem_chk.sv
l2_mem_top_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the l2 slice store testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module l2_mem_top_tb \
    -f l2_mem_top.f \
    -o sim_l2_mem

sim_out=$(./obj_dir/sim_l2_mem 2>&1) || true
echo "$sim_out"

if grep -qx "STATUS: PASS" <<< "$sim_out"; then
    exit 0
fi
echo "simulation did not pass"
exit 1
